//--- timer_params.svh
`ifndef TIMER_PARAMS_SVH
`define TIMER_PARAMS_SVH

// hart count is fixed by the address map
`define TIMER_N_HARTS 2

// apb data width
`define TIMER_DATA_W 32

// --------------------
// register offsets

// software interrupt bits, one word per hart
`define TIMER_ADDR_MSIP0  16'h0000
`define TIMER_ADDR_MSIP1  16'h0004

// shared time counter
`define TIMER_ADDR_MTIME  16'h0008
`define TIMER_ADDR_MTIMEH 16'h000C

// per-hart compare values
`define TIMER_ADDR_CMP0   16'h0010
`define TIMER_ADDR_CMP0H  16'h0014
`define TIMER_ADDR_CMP1   16'h0018
`define TIMER_ADDR_CMP1H  16'h001C

`endif

//--- timer_pkg.sv
`default_nettype none

`include "timer_params.svh"

package timer_pkg;

	// one apb bus word
	typedef logic [`TIMER_DATA_W-1:0] apb_word_t;

	// the two bus-visible halves of a 64-bit register
	typedef struct packed {
		apb_word_t hi;
		apb_word_t lo;
	} reg64_half_t;

	// full view for counting and compare, half view for bus access
	typedef union packed {
		logic [2*`TIMER_DATA_W-1:0] full;
		reg64_half_t                half;
	} reg64_u;

	// one bit per hart
	typedef logic [`TIMER_N_HARTS-1:0] hart_vec_t;

	// apb transfer sequencing
	typedef enum logic [1:0] {
		BUS_IDLE,
		BUS_RD_DONE,
		BUS_WR_DONE
	} bus_state_e;

endpackage

`default_nettype wire

//--- apb_timer_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

`include "timer_params.svh"

module apb_timer_ctrl import timer_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,

	input  logic [15:0] paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,

	input  reg64_u      mtime,
	input  reg64_u      mtimecmp0,
	input  reg64_u      mtimecmp1,
	input  hart_vec_t   soft_irq,

	output apb_word_t   prdata,
	output logic        pready,

	output logic        mtime_lo_we,
	output logic        mtime_hi_we,
	output hart_vec_t   cmp_lo_we,
	output hart_vec_t   cmp_hi_we,
	output hart_vec_t   msip_we
);

	bus_state_e state;
	logic       access;
	logic       wr_start;

	// --------------------
	// transfer sequencing

	assign access = psel && penable;

	// only the first access-phase cycle of a transfer may write
	assign wr_start = access && pwrite && (state == BUS_IDLE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= BUS_IDLE;
			pready <= 1'b0;
		end else begin
			case (state)
				BUS_IDLE: begin
					if (access) begin
						pready <= 1'b1;
						state  <= pwrite ? BUS_WR_DONE : BUS_RD_DONE;
					end
				end
				default: begin
					// pready lasts one cycle, then wait for the master to let go
					pready <= 1'b0;
					if (!access)
						state <= BUS_IDLE;
				end
			endcase
		end
	end

	// --------------------
	// write strobes

	assign mtime_lo_we  = wr_start && (paddr == `TIMER_ADDR_MTIME);
	assign mtime_hi_we  = wr_start && (paddr == `TIMER_ADDR_MTIMEH);
	assign cmp_lo_we[0] = wr_start && (paddr == `TIMER_ADDR_CMP0);
	assign cmp_hi_we[0] = wr_start && (paddr == `TIMER_ADDR_CMP0H);
	assign cmp_lo_we[1] = wr_start && (paddr == `TIMER_ADDR_CMP1);
	assign cmp_hi_we[1] = wr_start && (paddr == `TIMER_ADDR_CMP1H);
	assign msip_we[0]   = wr_start && (paddr == `TIMER_ADDR_MSIP0);
	assign msip_we[1]   = wr_start && (paddr == `TIMER_ADDR_MSIP1);

	// --------------------
	// read mux, undefined offsets read zero

	always_comb begin
		prdata = '0;
		case (paddr)
			`TIMER_ADDR_MSIP0:  prdata = {{(`TIMER_DATA_W-1){1'b0}}, soft_irq[0]};
			`TIMER_ADDR_MSIP1:  prdata = {{(`TIMER_DATA_W-1){1'b0}}, soft_irq[1]};
			`TIMER_ADDR_MTIME:  prdata = mtime.half.lo;
			`TIMER_ADDR_MTIMEH: prdata = mtime.half.hi;
			`TIMER_ADDR_CMP0:   prdata = mtimecmp0.half.lo;
			`TIMER_ADDR_CMP0H:  prdata = mtimecmp0.half.hi;
			`TIMER_ADDR_CMP1:   prdata = mtimecmp1.half.lo;
			`TIMER_ADDR_CMP1H:  prdata = mtimecmp1.half.hi;
			default:            prdata = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- tick_sync.sv
`default_nettype none
`timescale 1ns/1ps

module tick_sync #(
	parameter bit tick_is_nrz = 1'b0
) (
	input  logic clk,
	input  logic rst_n,
	input  logic tick,
	input  logic dbg_halt,
	output logic count_en
);

	generate
		if (tick_is_nrz) begin : g_nrz
			logic tick_s1;
			logic tick_s2;
			logic tick_prev;
			logic tick_evt;

			// two-flop synchroniser, then edge detect on the toggle
			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n) begin
					tick_s1   <= 1'b0;
					tick_s2   <= 1'b0;
					tick_prev <= 1'b0;
					tick_evt  <= 1'b0;
				end else begin
					tick_s1   <= tick;
					tick_s2   <= tick_s1;
					tick_prev <= tick_s2;
					tick_evt  <= tick_s2 ^ tick_prev;
				end
			end

			assign count_en = tick_evt && !dbg_halt;
		end else begin : g_level
			// tick is already a clk-synchronous level
			assign count_en = tick && !dbg_halt;
		end
	endgenerate

endmodule

`default_nettype wire

//--- mtime_counter.sv
`default_nettype none
`timescale 1ns/1ps

module mtime_counter import timer_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,

	input  logic      count_en,

	input  logic      mtime_lo_we,
	input  logic      mtime_hi_we,
	input  apb_word_t pwdata,

	output reg64_u    mtime
);

	logic half_write;

	assign half_write = mtime_lo_we || mtime_hi_we;

	// --------------------
	// counter

	// a bus write beats a tick in the same cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime.full <= '0;
		end else if (half_write) begin
			if (mtime_lo_we)
				mtime.half.lo <= pwdata;
			if (mtime_hi_we)
				mtime.half.hi <= pwdata;
		end else if (count_en) begin
			// carry from lo into hi comes for free on the full view
			mtime.full <= mtime.full + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- mtimecmp_unit.sv
`default_nettype none
`timescale 1ns/1ps

module mtimecmp_unit import timer_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,

	input  logic      cmp_lo_we,
	input  logic      cmp_hi_we,
	input  apb_word_t pwdata,

	input  reg64_u    mtime,

	output reg64_u    mtimecmp,
	output logic      timer_irq
);

	logic cmp_hit;

	// --------------------
	// compare register

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtimecmp.full <= '0;
		end else begin
			if (cmp_lo_we)
				mtimecmp.half.lo <= pwdata;
			if (cmp_hi_we)
				mtimecmp.half.hi <= pwdata;
		end
	end

	// --------------------
	// interrupt

	// unsigned 64-bit test, both operands are plain values
	assign cmp_hit = mtime.full >= mtimecmp.full;

	// one edge behind the compare inputs
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			timer_irq <= 1'b0;
		else
			timer_irq <= cmp_hit;
	end

endmodule

`default_nettype wire

//--- msip_bank.sv
`default_nettype none
`timescale 1ns/1ps

`include "timer_params.svh"

module msip_bank import timer_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,

	input  hart_vec_t msip_we,
	input  apb_word_t pwdata,

	output hart_vec_t soft_irq
);

	logic pwdata_nz;

	// any set bit in the written word raises the interrupt
	assign pwdata_nz = |pwdata;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			soft_irq <= '0;
		end else begin
			for (int h = 0; h < `TIMER_N_HARTS; h++) begin
				if (msip_we[h])
					soft_irq[h] <= pwdata_nz;
			end
		end
	end

endmodule

`default_nettype wire

//--- riscv_timer_top.sv
`default_nettype none
`timescale 1ns/1ps

module riscv_timer_top import timer_pkg::*; #(
	parameter bit tick_is_nrz = 1'b0
) (
	input  logic        clk,
	input  logic        rst_n,

	input  logic [15:0] paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  apb_word_t   pwdata,
	output apb_word_t   prdata,
	output logic        pready,

	input  logic        dbg_halt,
	input  logic        tick,

	output hart_vec_t   soft_irq,
	output hart_vec_t   timer_irq
);

	logic      count_en;
	reg64_u    mtime;
	reg64_u    mtimecmp0;
	reg64_u    mtimecmp1;
	logic      mtime_lo_we;
	logic      mtime_hi_we;
	hart_vec_t cmp_lo_we;
	hart_vec_t cmp_hi_we;
	hart_vec_t msip_we;

	// --------------------
	// bus side

	apb_timer_ctrl u_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.paddr       (paddr),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.mtime       (mtime),
		.mtimecmp0   (mtimecmp0),
		.mtimecmp1   (mtimecmp1),
		.soft_irq    (soft_irq),
		.prdata      (prdata),
		.pready      (pready),
		.mtime_lo_we (mtime_lo_we),
		.mtime_hi_we (mtime_hi_we),
		.cmp_lo_we   (cmp_lo_we),
		.cmp_hi_we   (cmp_hi_we),
		.msip_we     (msip_we)
	);

	// --------------------
	// time base

	tick_sync #(
		.tick_is_nrz (tick_is_nrz)
	) u_tick (
		.clk      (clk),
		.rst_n    (rst_n),
		.tick     (tick),
		.dbg_halt (dbg_halt),
		.count_en (count_en)
	);

	mtime_counter u_mtime (
		.clk         (clk),
		.rst_n       (rst_n),
		.count_en    (count_en),
		.mtime_lo_we (mtime_lo_we),
		.mtime_hi_we (mtime_hi_we),
		.pwdata      (pwdata),
		.mtime       (mtime)
	);

	// --------------------
	// per-hart interrupts

	mtimecmp_unit u_cmp0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmp_lo_we (cmp_lo_we[0]),
		.cmp_hi_we (cmp_hi_we[0]),
		.pwdata    (pwdata),
		.mtime     (mtime),
		.mtimecmp  (mtimecmp0),
		.timer_irq (timer_irq[0])
	);

	mtimecmp_unit u_cmp1 (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmp_lo_we (cmp_lo_we[1]),
		.cmp_hi_we (cmp_hi_we[1]),
		.pwdata    (pwdata),
		.mtime     (mtime),
		.mtimecmp  (mtimecmp1),
		.timer_irq (timer_irq[1])
	);

	msip_bank u_msip (
		.clk      (clk),
		.rst_n    (rst_n),
		.msip_we  (msip_we),
		.pwdata   (pwdata),
		.soft_irq (soft_irq)
	);

endmodule

`default_nettype wire

//--- tb_riscv_timer.sv
`default_nettype none
`timescale 1ns/1ps

`include "timer_params.svh"

module tb_riscv_timer import timer_pkg::*;;

	// the tests run for about 700 cycles
	localparam int MAX_CYCLES = 3000;

	logic        clk;
	logic        rst_n;
	logic [15:0] paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	apb_word_t   pwdata;
	apb_word_t   prdata;
	logic        pready;
	logic        dbg_halt;
	logic        tick;
	hart_vec_t   soft_irq;
	hart_vec_t   timer_irq;

	// reference model of the register file
	logic [63:0] mtime_m;
	logic [63:0] cmp_m [2];
	hart_vec_t   msip_m;
	integer      seed;
	int          cycle_count = 0;

	riscv_timer_top #(.tick_is_nrz(1'b0)) DUT (
		.clk(clk), .rst_n(rst_n),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready),
		.dbg_halt(dbg_halt), .tick(tick),
		.soft_irq(soft_irq), .timer_irq(timer_irq)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: the run went past %0d cycles", MAX_CYCLES);
			$display("SOME TESTS FAILED");
			$fatal(1, "simulation stopped by cycle limit");
		end
	end

	// --------------------
	// compare tasks

	task automatic check_word(input string name, input apb_word_t got, input apb_word_t exp);
		if (got !== exp) begin
			$display("error at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "data mismatch");
		end
	endtask

	task automatic check_harts(input string name, input hart_vec_t got, input hart_vec_t exp);
		if (got !== exp) begin
			$display("error at %0t: %s got %b expected %b", $time, name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "interrupt mismatch");
		end
	endtask

	task automatic protocol_fail(input string what);
		$display("at %0t: %s", $time, what);
		$display("SOME TESTS FAILED");
		$fatal(1, "bus protocol failure");
	endtask

	// --------------------
	// model

	function automatic apb_word_t expected_read(input logic [15:0] addr);
		case (addr)
			`TIMER_ADDR_MSIP0:  return {31'b0, msip_m[0]};
			`TIMER_ADDR_MSIP1:  return {31'b0, msip_m[1]};
			`TIMER_ADDR_MTIME:  return mtime_m[31:0];
			`TIMER_ADDR_MTIMEH: return mtime_m[63:32];
			`TIMER_ADDR_CMP0:   return cmp_m[0][31:0];
			`TIMER_ADDR_CMP0H:  return cmp_m[0][63:32];
			`TIMER_ADDR_CMP1:   return cmp_m[1][31:0];
			`TIMER_ADDR_CMP1H:  return cmp_m[1][63:32];
			default:            return '0;
		endcase
	endfunction

	// timer interrupt is pending while time has reached the compare value
	function automatic hart_vec_t expected_irq(input logic [63:0] t);
		return {t >= cmp_m[1], t >= cmp_m[0]};
	endfunction

	// --------------------
	// bus and tick drivers start and end 1 ns after a rising edge

	task automatic apb_access(input logic [15:0] addr, input logic wr, input apb_word_t wdata,
			output apb_word_t rdata);
		int waits;
		waits = 0;
		paddr  = addr;
		pwrite = wr;
		pwdata = wdata;
		psel   = 1'b1;
		@(posedge clk);
		#1 penable = 1'b1;
		do begin
			@(posedge clk);
			#1 waits++;
		end while (!pready && waits < 4);
		if (!pready)
			protocol_fail("the slave never completed the transfer");
		if (waits != 1)
			protocol_fail("pready did not rise one cycle after the access phase began");
		rdata   = prdata;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		@(posedge clk);
		#1;
		if (pready)
			protocol_fail("pready stayed high for more than one cycle");
	endtask

	task automatic apb_write(input logic [15:0] addr, input apb_word_t data);
		apb_word_t unused;
		apb_access(addr, 1'b1, data, unused);
		case (addr)
			`TIMER_ADDR_MSIP0:  msip_m[0] = |data;
			`TIMER_ADDR_MSIP1:  msip_m[1] = |data;
			`TIMER_ADDR_MTIME:  mtime_m[31:0] = data;
			`TIMER_ADDR_MTIMEH: mtime_m[63:32] = data;
			`TIMER_ADDR_CMP0:   cmp_m[0][31:0] = data;
			`TIMER_ADDR_CMP0H:  cmp_m[0][63:32] = data;
			`TIMER_ADDR_CMP1:   cmp_m[1][31:0] = data;
			`TIMER_ADDR_CMP1H:  cmp_m[1][63:32] = data;
			default: ;
		endcase
	endtask

	task automatic apb_read(input logic [15:0] addr, output apb_word_t data);
		apb_access(addr, 1'b0, '0, data);
	endtask

	task automatic tick_pulse(input int n);
		tick = 1'b1;
		repeat (n) @(posedge clk);
		#1 tick = 1'b0;
		if (!dbg_halt)
			mtime_m = mtime_m + n;
	endtask

	task automatic read_all_defined();
		apb_word_t data;
		for (int a = 0; a < 16'h0020; a += 4) begin
			apb_read(16'(a), data);
			check_word($sformatf("prdata at %h", 16'(a)), data, expected_read(16'(a)));
		end
	endtask

	task automatic write_cmp(input int h, input logic [63:0] value);
		apb_write(`TIMER_ADDR_CMP0 + 16'(8 * h), value[31:0]);
		apb_write(`TIMER_ADDR_CMP0H + 16'(8 * h), value[63:32]);
	endtask

	// --------------------
	// tests

	task automatic test_reset();
		read_all_defined();
		check_harts("soft_irq", soft_irq, '0);
		// both compare values are zero, so time zero already matches
		check_harts("timer_irq", timer_irq, expected_irq(mtime_m));
	endtask

	task automatic test_counting();
		apb_word_t data;
		int n;
		apb_write(`TIMER_ADDR_MTIME, $random(seed));
		apb_write(`TIMER_ADDR_MTIMEH, $random(seed));
		n = 1 + ({$random(seed)} % 20);
		tick_pulse(n);
		read_all_defined();
		// carry out of the low word
		apb_write(`TIMER_ADDR_MTIME, 32'hffff_fffe);
		apb_write(`TIMER_ADDR_MTIMEH, $random(seed));
		tick_pulse(3);
		apb_read(`TIMER_ADDR_MTIMEH, data);
		check_word("mtimeh after carry", data, mtime_m[63:32]);
		read_all_defined();
		dbg_halt = 1'b1;
		tick_pulse(5);
		dbg_halt = 1'b0;
		read_all_defined();
	endtask

	task automatic test_msip();
		apb_word_t w;
		for (int i = 0; i < 8; i++) begin
			w = $random(seed);
			if (w == '0)
				w = 32'h8000_0000;
			if (i % 3 == 2)
				w = '0;
			apb_write(i[0] ? `TIMER_ADDR_MSIP1 : `TIMER_ADDR_MSIP0, w);
			check_harts("soft_irq", soft_irq, msip_m);
			read_all_defined();
		end
	endtask

	task automatic test_compare();
		apb_write(`TIMER_ADDR_MTIMEH, $random(seed));
		apb_write(`TIMER_ADDR_MTIME, $random(seed) & 32'h0fff_ffff);
		write_cmp(0, mtime_m + 3);
		write_cmp(1, mtime_m + 6);
		check_harts("timer_irq", timer_irq, expected_irq(mtime_m));
		for (int i = 0; i < 8; i++) begin
			tick_pulse(1);
			// still showing the compare of the previous count
			check_harts("timer_irq", timer_irq, expected_irq(mtime_m - 1));
			@(posedge clk);
			#1 check_harts("timer_irq", timer_irq, expected_irq(mtime_m));
		end
		write_cmp(0, mtime_m + 50);
		check_harts("timer_irq", timer_irq, expected_irq(mtime_m));
		write_cmp(1, mtime_m + 90);
		check_harts("timer_irq", timer_irq, expected_irq(mtime_m));
		read_all_defined();
	endtask

	task automatic test_unused();
		apb_word_t data;
		logic [15:0] addr;
		for (int i = 0; i < 8; i++) begin
			addr = 16'($random(seed)) & 16'hfffc;
			if (i == 0)
				addr = 16'h0020;
			if (addr < 16'h0020)
				addr = addr | 16'h0020;
			apb_write(addr, $random(seed));
			apb_read(addr, data);
			check_word($sformatf("prdata at %h", addr), data, '0);
			read_all_defined();
		end
	endtask

	initial begin
		seed     = 87;
		rst_n    = 1'b0;
		paddr    = '0;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		pwdata   = '0;
		dbg_halt = 1'b0;
		tick     = 1'b0;
		mtime_m  = '0;
		cmp_m[0] = '0;
		cmp_m[1] = '0;
		msip_m   = '0;
		repeat (5) @(posedge clk);
		#1;
		check_harts("timer_irq in reset", timer_irq, '0);
		check_harts("soft_irq in reset", soft_irq, '0);
		rst_n = 1'b1;
		test_reset();
		test_counting();
		test_msip();
		test_compare();
		test_unused();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
timer_pkg.sv
apb_timer_ctrl.sv
tick_sync.sv
mtime_counter.sv
mtimecmp_unit.sv
msip_bank.sv
riscv_timer_top.sv
tb_riscv_timer.sv

//--- Makefile
# Verilator build for the machine-timer testbench

VERILATOR ?= verilator
TOP       ?= tb_riscv_timer
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= ALL TESTS PASSED

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell sed -n '/^[^+]/p' $(FILELIST)) timer_params.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
